// File: Makefile
VERILATOR  ?= verilator
LINT_FLAGS  = --lint-only --timing
SIM_FLAGS   = --binary --timing
TB_TOP      = tb_vtp_shim
RTL_TOP     = vtp_shim_top
FILELIST    = sources.f
BUILD_DIR   = obj_dir
LOG         = sim.log
PASS_MSG    = *** PASSED ***

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	grep -qF '$(PASS_MSG)' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/vtp_pkg.sv
// Shared types for the address translation shim.
// Every module refers to these by scoped name, so this package is compiled first.

package vtp_pkg;

    // ========================================
    // Address geometry
    // ========================================

    // Pages are 4KB, so the low 12 bits of an address pass through untranslated
    localparam int PAGE_OFFSET_BITS = 12;

    // Each page table entry occupies one 64-bit word
    localparam int PTE_BYTES = 8;

    typedef logic [31:0] va_t;
    typedef logic [31:0] pa_t;
    typedef logic [19:0] vpn_t;
    typedef logic [19:0] ppn_t;
    typedef logic [6:0]  client_tag_t;

    // ========================================
    // Channel payloads
    // ========================================

    // The walk bit marks page table reads so their responses can be steered back
    typedef struct packed {
        logic        walk;
        client_tag_t tag;
    } mem_tag_t;

    typedef struct packed {
        va_t         va;
        client_tag_t tag;
    } afu_req_t;

    typedef struct packed {
        pa_t      addr;
        mem_tag_t tag;
    } mem_req_t;

    typedef struct packed {
        logic [63:0] data;
        mem_tag_t    tag;
    } mem_rsp_t;

    typedef enum logic [0:0] {
        RSP_OK    = 1'b0,
        RSP_FAULT = 1'b1
    } rsp_status_t;

    typedef struct packed {
        logic [63:0] data;
        client_tag_t tag;
        rsp_status_t status;
    } afu_rsp_t;

    // Entry layout in the low bits of a memory word, present bit at bit 0
    typedef struct packed {
        logic [42:0] rsvd;
        ppn_t        ppn;
        logic        present;
    } pte_t;

    // ========================================
    // Internal control
    // ========================================

    typedef enum logic [1:0] {
        XS_IDLE,
        XS_LOOKUP,
        XS_WALK,
        XS_FAULT
    } xlate_state_t;

    typedef struct packed {
        vpn_t vpn;
        ppn_t ppn;
    } tlb_fill_t;

endpackage

// File: rtl/mem_req_arb.sv
// Shares one memory port between the translator and the page table walker.
// Purely combinational, with walker requests first and responses routed by their walk bit.

module mem_req_arb
(
    input  vtp_pkg::mem_req_t  xl_mem_req,
    input  logic               xl_mem_req_valid,
    output logic               xl_mem_req_ready,

    input  vtp_pkg::mem_req_t  pw_mem_req,
    input  logic               pw_mem_req_valid,
    output logic               pw_mem_req_ready,

    output vtp_pkg::mem_req_t  mem_req,
    output logic               mem_req_valid,
    input  logic               mem_req_ready,

    input  vtp_pkg::mem_rsp_t  mem_rsp,
    input  logic               mem_rsp_valid,
    output logic               mem_rsp_ready,

    output vtp_pkg::mem_rsp_t  pw_rsp,
    output logic               pw_rsp_valid,

    output vtp_pkg::afu_rsp_t  afu_rsp,
    output logic               afu_rsp_valid,
    input  logic               afu_rsp_ready,

    input  vtp_pkg::afu_rsp_t  xl_fault,
    input  logic               xl_fault_valid,
    output logic               xl_fault_ready
);

    // ========================================
    // Request side
    // ========================================

    // Walker reads win, since a pending walk is what holds up the client
    assign mem_req_valid    = pw_mem_req_valid || xl_mem_req_valid;
    assign mem_req          = pw_mem_req_valid ? pw_mem_req : xl_mem_req;
    assign pw_mem_req_ready = mem_req_ready;
    assign xl_mem_req_ready = mem_req_ready && !pw_mem_req_valid;

    // ========================================
    // Response side
    // ========================================

    logic client_rsp_valid;

    assign pw_rsp           = mem_rsp;
    assign pw_rsp_valid     = mem_rsp_valid && mem_rsp.tag.walk;
    assign client_rsp_valid = mem_rsp_valid && !mem_rsp.tag.walk;

    // Walk responses are always drained, even while the client stalls
    assign mem_rsp_ready = mem_rsp.tag.walk || afu_rsp_ready;

    // Faults take the response port only when no memory data is waiting
    assign afu_rsp_valid  = client_rsp_valid || xl_fault_valid;
    assign xl_fault_ready = afu_rsp_ready && !client_rsp_valid;
    assign afu_rsp        = client_rsp_valid ?
                            '{data: mem_rsp.data, tag: mem_rsp.tag.tag, status: vtp_pkg::RSP_OK} :
                            xl_fault;

endmodule

// File: rtl/vtp_shim_top.sv
// Top level of the translation shim between a virtual-address client and a memory port.
// Connects the translator, TLB, walker and memory arbiter.

module vtp_shim_top
#(
    parameter int TLB_ENTRIES = 16
)
(
    input  logic               clk,
    input  logic               reset,
    input  vtp_pkg::pa_t       pt_base,

    input  vtp_pkg::afu_req_t  afu_req,
    input  logic               afu_req_valid,
    output logic               afu_req_ready,

    output vtp_pkg::afu_rsp_t  afu_rsp,
    output logic               afu_rsp_valid,
    input  logic               afu_rsp_ready,

    output vtp_pkg::mem_req_t  mem_req,
    output logic               mem_req_valid,
    input  logic               mem_req_ready,

    input  vtp_pkg::mem_rsp_t  mem_rsp,
    input  logic               mem_rsp_valid,
    output logic               mem_rsp_ready
);

    // Translator to arbiter
    vtp_pkg::mem_req_t  xl_mem_req;
    logic               xl_mem_req_valid;
    logic               xl_mem_req_ready;
    vtp_pkg::afu_rsp_t  xl_fault;
    logic               xl_fault_valid;
    logic               xl_fault_ready;

    // Translator to TLB
    logic               lookup_en;
    vtp_pkg::vpn_t      lookup_vpn;
    logic               lookup_hit;
    vtp_pkg::ppn_t      lookup_ppn;

    // Translator to walker, and walker to TLB and arbiter
    vtp_pkg::vpn_t      walk_vpn;
    logic               walk_valid;
    logic               walk_ready;
    logic               walk_done;
    logic               walk_fault;
    logic               fill_en;
    vtp_pkg::tlb_fill_t tlb_fill;
    vtp_pkg::mem_req_t  pw_mem_req;
    logic               pw_mem_req_valid;
    logic               pw_mem_req_ready;
    vtp_pkg::mem_rsp_t  pw_rsp;
    logic               pw_rsp_valid;

    vtp_translate xlate
    (
        .clk, .reset,
        .afu_req, .afu_req_valid, .afu_req_ready,
        .xl_mem_req, .xl_mem_req_valid, .xl_mem_req_ready,
        .lookup_en, .lookup_vpn, .lookup_hit, .lookup_ppn,
        .walk_vpn, .walk_valid, .walk_ready, .walk_done, .walk_fault,
        .xl_fault, .xl_fault_valid, .xl_fault_ready
    );

    vtp_tlb
    #(
        .TLB_ENTRIES(TLB_ENTRIES)
    )
    tlb
    (
        .clk, .reset,
        .lookup_en, .lookup_vpn, .lookup_hit, .lookup_ppn,
        .fill_en, .tlb_fill
    );

    vtp_pt_walk walker
    (
        .clk, .reset, .pt_base,
        .walk_vpn, .walk_valid, .walk_ready,
        .pw_mem_req, .pw_mem_req_valid, .pw_mem_req_ready,
        .pw_rsp, .pw_rsp_valid,
        .fill_en, .tlb_fill, .walk_done, .walk_fault
    );

    mem_req_arb arb
    (
        .xl_mem_req, .xl_mem_req_valid, .xl_mem_req_ready,
        .pw_mem_req, .pw_mem_req_valid, .pw_mem_req_ready,
        .mem_req, .mem_req_valid, .mem_req_ready,
        .mem_rsp, .mem_rsp_valid, .mem_rsp_ready,
        .pw_rsp, .pw_rsp_valid,
        .afu_rsp, .afu_rsp_valid, .afu_rsp_ready,
        .xl_fault, .xl_fault_valid, .xl_fault_ready
    );

endmodule

// File: sources.f
common/vtp_pkg.sv
vtp/vtp_tlb.sv
vtp/vtp_translate.sv
vtp/vtp_pt_walk.sv
rtl/mem_req_arb.sv
rtl/vtp_shim_top.sv
tests/tb_mem_model.sv
tests/tb_vtp_shim.sv

// File: tests/tb_mem_model.sv
// Behavioral memory for the translation shim testbench.
// Serves reads in order with a varying latency, holds the page table image and logs requests.

module tb_mem_model
(
    input  logic              clk,
    input  logic              reset,
    input  vtp_pkg::pa_t      pt_base,

    // Marks one virtual page as present in the page table image
    input  logic              map_en,
    input  vtp_pkg::vpn_t     map_vpn,

    input  vtp_pkg::mem_req_t mem_req,
    input  logic              mem_req_valid,
    output logic              mem_req_ready,

    output vtp_pkg::mem_rsp_t mem_rsp,
    output logic              mem_rsp_valid,
    input  logic              mem_rsp_ready
);

    logic              ready_q = 1'b0;
    vtp_pkg::mem_rsp_t rsp_q = '0;
    logic              rsp_valid_q = 1'b0;
    logic [31:0]       lat_lfsr = 32'ha04;
    int                cycle = 0;

    // Reads in flight with the cycle each one may answer, oldest first
    vtp_pkg::mem_req_t pend_q[$];
    int                due_q[$];
    vtp_pkg::vpn_t     mapped_q[$];

    // Every request seen at the port, drained by the testbench after each test
    vtp_pkg::mem_req_t req_log[$];

    assign mem_req_ready = ready_q;
    assign mem_rsp       = rsp_q;
    assign mem_rsp_valid = rsp_valid_q;

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic is_mapped(input vtp_pkg::vpn_t vpn);
        foreach (mapped_q[i])
        begin
            if (mapped_q[i] == vpn)
            begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    // The table covers 2^20 entries of 8 bytes, everything else is the data pattern
    function automatic logic [63:0] read_word(input vtp_pkg::pa_t addr);
        vtp_pkg::pa_t  offset;
        vtp_pkg::vpn_t vpn;
        vtp_pkg::pte_t pte;
        offset = addr - pt_base;
        if ((addr >= pt_base) && (offset < (32'h1 << 23)))
        begin
            vpn         = vtp_pkg::vpn_t'(offset >> 3);
            pte         = '0;
            pte.present = is_mapped(vpn);
            pte.ppn     = vpn ^ 20'h5a5a5;
            return pte;
        end
        return {~addr, addr};
    endfunction

    always @(posedge clk)
    begin
        logic [1:0] lat;
        if (map_en)
        begin
            mapped_q.push_back(map_vpn);
        end

        if (!reset)
        begin
            pend_q.delete();
            due_q.delete();
            ready_q     <= 1'b0;
            rsp_valid_q <= 1'b0;
        end
        else
        begin
            cycle++;
            ready_q <= 1'b1;

            // The head leaves once the shim has taken it
            if (rsp_valid_q && mem_rsp_ready)
            begin
                void'(pend_q.pop_front());
                void'(due_q.pop_front());
            end

            // Two LFSR bits give an extra 0 to 3 cycles on top of the minimum of one
            if (mem_req_valid && ready_q)
            begin
                lat_lfsr = lfsr_step(lat_lfsr);
                lat[0]   = lat_lfsr[0];
                lat_lfsr = lfsr_step(lat_lfsr);
                lat[1]   = lat_lfsr[0];
                pend_q.push_back(mem_req);
                due_q.push_back(cycle + 1 + int'(lat));
                req_log.push_back(mem_req);
            end

            // Only the head may answer, which keeps responses in request order
            if ((pend_q.size() > 0) && (due_q[0] <= cycle))
            begin
                rsp_q       <= '{data: read_word(pend_q[0].addr), tag: pend_q[0].tag};
                rsp_valid_q <= 1'b1;
            end
            else
            begin
                rsp_valid_q <= 1'b0;
            end
        end
    end

endmodule

// File: tests/tb_vtp_shim.sv
// Testbench for the translation shim.
// Applies a table of client reads, checks memory traffic and responses, then prints a verdict.

module tb_vtp_shim;

    localparam int           NUM_TESTS      = 11;
    localparam int           TIMEOUT_CYCLES = 40 * NUM_TESTS;
    localparam vtp_pkg::pa_t PT_BASE        = 32'h0010_0000;

    // One client read with the status and number of walk reads it should cause
    typedef struct packed {
        vtp_pkg::va_t         va;
        vtp_pkg::client_tag_t tag;
        vtp_pkg::rsp_status_t status;
        logic [3:0]           walks;
    } stim_t;

    // ========================================
    // Stimulus table
    // ========================================

    // Pages 345 and 675 share TLB index 5, page abc is absent from the table
    localparam stim_t STIM [NUM_TESTS] = '{
        '{32'h0001_2340, 7'd1,   vtp_pkg::RSP_OK,    4'd1},
        '{32'h0001_2008, 7'd2,   vtp_pkg::RSP_OK,    4'd0},
        '{32'h0001_2ff8, 7'd3,   vtp_pkg::RSP_OK,    4'd0},
        '{32'h00ab_c100, 7'd4,   vtp_pkg::RSP_FAULT, 4'd1},
        '{32'h0034_5010, 7'd5,   vtp_pkg::RSP_OK,    4'd1},
        '{32'h0067_5020, 7'd6,   vtp_pkg::RSP_OK,    4'd1},
        '{32'h0034_5030, 7'd7,   vtp_pkg::RSP_OK,    4'd1},
        '{32'h0067_5040, 7'd8,   vtp_pkg::RSP_OK,    4'd1},
        '{32'h00ab_c200, 7'd9,   vtp_pkg::RSP_FAULT, 4'd1},
        '{32'h0001_27f0, 7'd10,  vtp_pkg::RSP_OK,    4'd0},
        '{32'h0034_5abc, 7'd127, vtp_pkg::RSP_OK,    4'd1}
    };

    logic                 clk = 1'b0;
    logic                 reset;
    vtp_pkg::pa_t         pt_base;
    vtp_pkg::afu_req_t    afu_req;
    logic                 afu_req_valid;
    logic                 afu_req_ready;
    vtp_pkg::afu_rsp_t    afu_rsp;
    logic                 afu_rsp_valid;
    logic                 afu_rsp_ready = 1'b0;
    vtp_pkg::mem_req_t    mem_req;
    logic                 mem_req_valid;
    logic                 mem_req_ready;
    vtp_pkg::mem_rsp_t    mem_rsp;
    logic                 mem_rsp_valid;
    logic                 mem_rsp_ready;
    logic                 map_en;
    vtp_pkg::vpn_t        map_vpn;

    logic [31:0]          rsp_lfsr = 32'ha04;
    int                   cycle_count = 0;
    int                   rsp_count = 0;
    int                   error_count = 0;
    int                   pass_count = 0;
    int                   fail_count = 0;

    always #50 clk = ~clk;

    vtp_shim_top #(.TLB_ENTRIES(16)) dut0
    (
        .clk, .reset, .pt_base,
        .afu_req, .afu_req_valid, .afu_req_ready,
        .afu_rsp, .afu_rsp_valid, .afu_rsp_ready,
        .mem_req, .mem_req_valid, .mem_req_ready,
        .mem_rsp, .mem_rsp_valid, .mem_rsp_ready
    );

    tb_mem_model mem0
    (
        .clk, .reset, .pt_base, .map_en, .map_vpn,
        .mem_req, .mem_req_valid, .mem_req_ready,
        .mem_rsp, .mem_rsp_valid, .mem_rsp_ready
    );

    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // Client back-pressure, one LFSR step per cycle
    always @(posedge clk)
    begin
        rsp_lfsr = next_lfsr(rsp_lfsr);
        afu_rsp_ready <= rsp_lfsr[0];
    end

    // Counts every response handshake so duplicates show up at the end
    always @(posedge clk)
    begin
        if (reset && afu_rsp_valid && afu_rsp_ready)
        begin
            rsp_count <= rsp_count + 1;
        end
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    // ========================================
    // Compare tasks
    // ========================================

    task automatic compare_rsp(input string what, input vtp_pkg::afu_rsp_t got,
                               input vtp_pkg::afu_rsp_t exp);
        if (got !== exp)
        begin
            $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic compare_mem_req(input string what, input vtp_pkg::mem_req_t got,
                                   input vtp_pkg::mem_req_t exp);
        if (got !== exp)
        begin
            $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
            error_count++;
        end
    endtask

    task automatic compare_count(input string what, input int got, input int exp);
        if (got != exp)
        begin
            $display("** Error at %0t: %s got %0d expected %0d", $time, what, got, exp);
            error_count++;
        end
    endtask

    // ========================================
    // One table entry
    // ========================================

    task automatic run_test(input int idx);
        stim_t             s;
        vtp_pkg::vpn_t     vpn;
        vtp_pkg::pa_t      pa;
        vtp_pkg::afu_rsp_t got;
        vtp_pkg::afu_rsp_t exp_rsp;
        vtp_pkg::mem_req_t seen;
        vtp_pkg::mem_req_t exp_walk;
        vtp_pkg::mem_req_t exp_read;
        int                walks;
        int                reads;
        int                errors_before;
        s             = STIM[idx];
        vpn           = s.va[31:12];
        pa            = {vpn ^ 20'h5a5a5, s.va[11:0]};
        walks         = 0;
        reads         = 0;
        errors_before = error_count;
        exp_walk      = '{addr: PT_BASE + vtp_pkg::pa_t'(vpn) * 32'd8, tag: '{1'b1, 7'd0}};
        exp_read      = '{addr: pa, tag: '{1'b0, s.tag}};
        if (s.status == vtp_pkg::RSP_OK)
        begin
            exp_rsp = '{data: {~pa, pa}, tag: s.tag, status: vtp_pkg::RSP_OK};
        end
        else
        begin
            exp_rsp = '{data: '0, tag: s.tag, status: vtp_pkg::RSP_FAULT};
        end

        @(posedge clk);
        afu_req       <= '{va: s.va, tag: s.tag};
        afu_req_valid <= 1'b1;
        do @(posedge clk); while (!afu_req_ready);
        afu_req_valid <= 1'b0;

        do @(posedge clk); while (!(afu_rsp_valid && afu_rsp_ready));
        got = afu_rsp;

        // The read and any walk were issued before the response came back
        while (mem0.req_log.size() > 0)
        begin
            seen = mem0.req_log.pop_front();
            if (seen.tag.walk)
            begin
                walks++;
                compare_mem_req("walk read", seen, exp_walk);
            end
            else
            begin
                reads++;
                compare_mem_req("client read", seen, exp_read);
            end
        end
        compare_count("walk reads", walks, int'(s.walks));
        compare_count("client reads", reads, (s.status == vtp_pkg::RSP_OK) ? 1 : 0);
        compare_rsp("response", got, exp_rsp);

        if (error_count == errors_before)
        begin
            pass_count++;
            $display("test %0d va %h tag %0d walks %0d: pass", idx, s.va, s.tag, walks);
        end
        else
        begin
            fail_count++;
            $display("test %0d va %h tag %0d walks %0d: fail", idx, s.va, s.tag, walks);
        end
    endtask

    initial
    begin
        reset         = 1'b0;
        pt_base       = PT_BASE;
        afu_req       = '0;
        afu_req_valid = 1'b0;
        map_en        = 1'b0;
        map_vpn       = '0;

        repeat (4) @(posedge clk);
        reset <= 1'b1;

        // Every page that should translate gets a present entry
        for (int i = 0; i < NUM_TESTS; i++)
        begin
            if (STIM[i].status == vtp_pkg::RSP_OK)
            begin
                @(posedge clk);
                map_en  <= 1'b1;
                map_vpn <= STIM[i].va[31:12];
            end
        end
        @(posedge clk);
        map_en <= 1'b0;

        for (int i = 0; i < NUM_TESTS; i++)
        begin
            run_test(i);
        end

        // Leave room for any stray response before counting
        repeat (10) @(posedge clk);
        compare_count("responses", rsp_count, NUM_TESTS);

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 NUM_TESTS, pass_count, fail_count, error_count);
        if (error_count == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: vtp/vtp_pt_walk.sv
// Page table walker for a flat, single-level table at pt_base.
// Reads one entry per walk and either fills the TLB or reports a fault.

module vtp_pt_walk
(
    input  logic                clk,
    input  logic                reset,

    input  vtp_pkg::pa_t        pt_base,

    input  vtp_pkg::vpn_t       walk_vpn,
    input  logic                walk_valid,
    output logic                walk_ready,

    output vtp_pkg::mem_req_t   pw_mem_req,
    output logic                pw_mem_req_valid,
    input  logic                pw_mem_req_ready,

    input  vtp_pkg::mem_rsp_t   pw_rsp,
    input  logic                pw_rsp_valid,

    output logic                fill_en,
    output vtp_pkg::tlb_fill_t  tlb_fill,
    output logic                walk_done,
    output logic                walk_fault
);

    // Busy from walk accept until the entry has been decoded
    logic          busy;
    vtp_pkg::vpn_t vpn_q;
    vtp_pkg::pte_t pte;

    assign walk_ready = !busy;

    // The entry sits in the low bits of the returned word
    assign pte = vtp_pkg::pte_t'(pw_rsp.data);

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            busy             <= 1'b0;
            pw_mem_req_valid <= 1'b0;
            fill_en          <= 1'b0;
            walk_done        <= 1'b0;
            walk_fault       <= 1'b0;
        end
        else
        begin
            // Completion signals are single-cycle pulses
            fill_en    <= 1'b0;
            walk_done  <= 1'b0;
            walk_fault <= 1'b0;

            if (walk_valid && walk_ready)
            begin
                busy             <= 1'b1;
                pw_mem_req_valid <= 1'b1;
            end
            else if (pw_mem_req_valid && pw_mem_req_ready)
            begin
                pw_mem_req_valid <= 1'b0;
            end

            // A response only ever comes back for the single read in flight
            if (busy && pw_rsp_valid)
            begin
                busy       <= 1'b0;
                fill_en    <= pte.present;
                walk_done  <= pte.present;
                walk_fault <= !pte.present;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (walk_valid && walk_ready)
        begin
            vpn_q               <= walk_vpn;
            pw_mem_req.addr     <= pt_base + vtp_pkg::pa_t'(walk_vpn) * vtp_pkg::PTE_BYTES;
            pw_mem_req.tag.walk <= 1'b1;
            pw_mem_req.tag.tag  <= '0;
        end

        if (busy && pw_rsp_valid)
        begin
            tlb_fill.vpn <= vpn_q;
            tlb_fill.ppn <= pte.ppn;
        end
    end

endmodule

// File: vtp/vtp_tlb.sv
// Direct-mapped TLB for 4KB pages.
// Lookups answer one cycle after lookup_en and fills complete in a single cycle.

module vtp_tlb
#(
    parameter int TLB_ENTRIES = 16
)
(
    input  logic               clk,
    input  logic               reset,

    input  logic               lookup_en,
    input  vtp_pkg::vpn_t      lookup_vpn,
    output logic               lookup_hit,
    output vtp_pkg::ppn_t      lookup_ppn,

    input  logic               fill_en,
    input  vtp_pkg::tlb_fill_t tlb_fill
);

    // The low vpn bits pick the entry and the remaining bits form the tag
    localparam int IDX_BITS = $clog2(TLB_ENTRIES);
    localparam int TAG_BITS = $bits(vtp_pkg::vpn_t) - IDX_BITS;

    logic [TLB_ENTRIES-1:0] entry_valid;
    logic [TAG_BITS-1:0]    entry_tag [TLB_ENTRIES];
    vtp_pkg::ppn_t          entry_ppn [TLB_ENTRIES];

    // Lookup address captured on lookup_en and compared in the following cycle
    logic [IDX_BITS-1:0]    idx_q;
    logic [TAG_BITS-1:0]    tag_q;

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            idx_q <= '0;
            tag_q <= '0;
        end
        else if (lookup_en)
        begin
            idx_q <= lookup_vpn[IDX_BITS-1:0];
            tag_q <= lookup_vpn[$bits(vtp_pkg::vpn_t)-1:IDX_BITS];
        end
    end

    // Each fill marks its slot valid until the next reset
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            entry_valid <= '0;
        end
        else if (fill_en)
        begin
            entry_valid[tlb_fill.vpn[IDX_BITS-1:0]] <= 1'b1;
        end
    end

    // A fill simply overwrites its slot, so aliasing pages evict each other
    always_ff @(posedge clk)
    begin
        if (fill_en)
        begin
            entry_tag[tlb_fill.vpn[IDX_BITS-1:0]] <=
                tlb_fill.vpn[$bits(vtp_pkg::vpn_t)-1:IDX_BITS];
            entry_ppn[tlb_fill.vpn[IDX_BITS-1:0]] <= tlb_fill.ppn;
        end
    end

    // The compare reads the array after any fill from the lookup cycle has landed
    assign lookup_hit = entry_valid[idx_q] && (entry_tag[idx_q] == tag_q);
    assign lookup_ppn = entry_ppn[idx_q];

endmodule

// File: vtp/vtp_translate.sv
// Translation control for client reads, one request in flight at a time.
// Hits go straight to memory, misses go through the walker and are then replayed.

module vtp_translate
(
    input  logic                clk,
    input  logic                reset,

    input  vtp_pkg::afu_req_t   afu_req,
    input  logic                afu_req_valid,
    output logic                afu_req_ready,

    output vtp_pkg::mem_req_t   xl_mem_req,
    output logic                xl_mem_req_valid,
    input  logic                xl_mem_req_ready,

    output logic                lookup_en,
    output vtp_pkg::vpn_t       lookup_vpn,
    input  logic                lookup_hit,
    input  vtp_pkg::ppn_t       lookup_ppn,

    output vtp_pkg::vpn_t       walk_vpn,
    output logic                walk_valid,
    input  logic                walk_ready,
    input  logic                walk_done,
    input  logic                walk_fault,

    output vtp_pkg::afu_rsp_t   xl_fault,
    output logic                xl_fault_valid,
    input  logic                xl_fault_ready
);

    vtp_pkg::xlate_state_t state;

    // The accepted request, held until its read or fault has been handed off
    vtp_pkg::afu_req_t req_q;

    logic req_accept;
    assign req_accept = (state == vtp_pkg::XS_IDLE) && afu_req_valid && afu_req_ready;

    // ========================================
    // TLB lookup
    // ========================================

    // First lookup uses the incoming address, a replay uses the held one
    assign lookup_en  = req_accept || ((state == vtp_pkg::XS_WALK) && walk_done);
    assign lookup_vpn = (state == vtp_pkg::XS_IDLE) ?
                        vtp_pkg::vpn_t'(afu_req.va >> vtp_pkg::PAGE_OFFSET_BITS) :
                        vtp_pkg::vpn_t'(req_q.va >> vtp_pkg::PAGE_OFFSET_BITS);

    assign walk_vpn = vtp_pkg::vpn_t'(req_q.va >> vtp_pkg::PAGE_OFFSET_BITS);

    // Fault payload is fixed while in XS_FAULT because req_q does not change
    assign xl_fault = '{data: '0, tag: req_q.tag, status: vtp_pkg::RSP_FAULT};

    always_ff @(posedge clk)
    begin
        if (req_accept)
        begin
            req_q <= afu_req;
        end

        // Capture the physical address on the hit, before the valid goes up
        if ((state == vtp_pkg::XS_LOOKUP) && !xl_mem_req_valid)
        begin
            xl_mem_req.addr     <= {lookup_ppn, req_q.va[vtp_pkg::PAGE_OFFSET_BITS-1:0]};
            xl_mem_req.tag.walk <= 1'b0;
            xl_mem_req.tag.tag  <= req_q.tag;
        end
    end

    // ========================================
    // State machine
    // ========================================

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state            <= vtp_pkg::XS_IDLE;
            afu_req_ready    <= 1'b0;
            xl_mem_req_valid <= 1'b0;
            walk_valid       <= 1'b0;
            xl_fault_valid   <= 1'b0;
        end
        else
        begin
            unique case (state)
                vtp_pkg::XS_IDLE:
                begin
                    // Ready rises the first cycle after reset and drops on accept
                    if (req_accept)
                    begin
                        afu_req_ready <= 1'b0;
                        state         <= vtp_pkg::XS_LOOKUP;
                    end
                    else
                    begin
                        afu_req_ready <= 1'b1;
                    end
                end

                vtp_pkg::XS_LOOKUP:
                begin
                    if (xl_mem_req_valid)
                    begin
                        // Wait here until the arbiter takes the read
                        if (xl_mem_req_ready)
                        begin
                            xl_mem_req_valid <= 1'b0;
                            afu_req_ready    <= 1'b1;
                            state            <= vtp_pkg::XS_IDLE;
                        end
                    end
                    else if (lookup_hit)
                    begin
                        xl_mem_req_valid <= 1'b1;
                    end
                    else
                    begin
                        // Miss, so hand the page to the walker
                        walk_valid <= 1'b1;
                        state      <= vtp_pkg::XS_WALK;
                    end
                end

                vtp_pkg::XS_WALK:
                begin
                    if (walk_valid && walk_ready)
                    begin
                        walk_valid <= 1'b0;
                    end

                    // walk_done already issued the replay lookup above
                    if (walk_done)
                    begin
                        state <= vtp_pkg::XS_LOOKUP;
                    end
                    else if (walk_fault)
                    begin
                        xl_fault_valid <= 1'b1;
                        state          <= vtp_pkg::XS_FAULT;
                    end
                end

                vtp_pkg::XS_FAULT:
                begin
                    if (xl_fault_ready)
                    begin
                        xl_fault_valid <= 1'b0;
                        afu_req_ready  <= 1'b1;
                        state          <= vtp_pkg::XS_IDLE;
                    end
                end

                default:
                begin
                    state <= vtp_pkg::XS_IDLE;
                end
            endcase
        end
    end

endmodule
